// File: hw/sample_pkg.sv
package sample_pkg;

    // Sample and bank geometry
    localparam int sample_width = 10;
    localparam int addr_width   = 4;
    localparam int bank_depth   = 16; // Write pointer wraps here

    // UART oversampling, clock cycles per serial bit
    localparam int clks_per_bit = 16;

    // Bank address
    typedef logic [addr_width-1:0] addr_t;

    // One sample word, seen either whole or as the two received bytes
    typedef union packed {
        logic [sample_width-1:0] value;
        struct packed {
            logic [1:0] hi; // Low bits of the second byte
            logic [7:0] lo; // First byte
        } parts;
    } sample_t;

endpackage

// File: hw/bank_if.sv
`timescale 1ns/10ps

interface bank_if;
    import sample_pkg::*;

    logic    wr_en;   // One-cycle write strobe
    addr_t   wr_addr;
    sample_t wr_data;
    addr_t   rd_addr;
    sample_t rd_data; // Valid one cycle after rd_addr

    modport writer (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport bank (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: hw/uart_byte_rx.sv
`timescale 1ns/10ps

module uart_byte_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    import sample_pkg::*;

    enum logic [1:0] {s_idle, s_start, s_data, s_stop} state;

    logic                            rx_meta;
    logic                            rx_sync;
    logic [$clog2(clks_per_bit)-1:0] tick_cnt; // Cycles within the current bit
    logic [2:0]                      bit_idx;
    logic                            bit_end;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign bit_end = (tick_cnt == clks_per_bit - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                s_idle: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    if (!rx_sync)
                        state <= s_start;
                end
                s_start: begin
                    // Recheck the line half a bit in
                    if (tick_cnt == clks_per_bit / 2 - 1) begin
                        tick_cnt <= '0;
                        if (rx_sync)
                            state <= s_idle; // False start
                        else
                            state <= s_data;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                s_data: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= s_stop;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                s_stop: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        rx_valid <= rx_sync; // Drop the byte on a bad stop bit
                        state    <= s_idle;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == s_data && bit_end)
            rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

// File: hw/sample_writer.sv
`timescale 1ns/10ps

module sample_writer (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    input  logic        cap_req,
    input  logic        cap_bank,
    output logic        cap_ack,
    bank_if.writer      bank0,
    bank_if.writer      bank1
);
    import sample_pkg::*;

    enum logic [2:0] {
        s_idle,
        s_wait_lo,
        s_wait_hi,
        s_write,
        s_ack,
        s_release
    } state;

    logic    bank_sel; // Bank chosen for the capture in progress
    sample_t sample;
    addr_t   wr_ptr;   // Shared by both banks

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_idle;
            bank_sel <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (cap_req) begin
                        bank_sel <= cap_bank;
                        state    <= s_wait_lo;
                    end
                end
                s_wait_lo: begin
                    if (rx_valid)
                        state <= s_wait_hi;
                end
                s_wait_hi: begin
                    if (rx_valid)
                        state <= s_write;
                end
                s_write: begin
                    state <= s_ack;
                end
                s_ack: begin
                    // Hold ack until the host lets go
                    if (!cap_req)
                        state <= s_release;
                end
                s_release: begin
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Assemble the two bytes into one sample
    always_ff @(posedge clk) begin
        if (state == s_wait_lo && rx_valid)
            sample.parts.lo <= rx_data;
        if (state == s_wait_hi && rx_valid)
            sample.parts.hi <= rx_data[1:0]; // Upper six bits unused
    end

    // Advances as the ack goes up, wraps at bank_depth
    always_ff @(posedge clk) begin
        if (reset)
            wr_ptr <= '0;
        else if (state == s_write)
            wr_ptr <= wr_ptr + 1'b1;
    end

    assign cap_ack = (state == s_ack);

    assign bank0.wr_en   = (state == s_write) && !bank_sel;
    assign bank0.wr_addr = wr_ptr;
    assign bank0.wr_data = sample;

    assign bank1.wr_en   = (state == s_write) && bank_sel;
    assign bank1.wr_addr = wr_ptr;
    assign bank1.wr_data = sample;

endmodule

// File: hw/sample_bank.sv
`timescale 1ns/10ps

module sample_bank (
    input  logic clk,
    bank_if.bank port
);
    import sample_pkg::*;

    sample_t mem [0:bank_depth-1];

    // A read of the address being written returns the old word
    always_ff @(posedge clk) begin
        if (port.wr_en)
            mem[port.wr_addr] <= port.wr_data;
        port.rd_data <= mem[port.rd_addr];
    end

endmodule

// File: hw/bank_reader.sv
`timescale 1ns/10ps

module bank_reader (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_req,
    input  sample_pkg::addr_t rd_addr,
    input  logic              rd_bank,
    output logic              rd_ack,
    output sample_pkg::sample_t rd_data,
    bank_if.reader            bank0,
    bank_if.reader            bank1
);
    import sample_pkg::*;

    enum logic [1:0] {s_idle, s_addr, s_capture, s_hold} state;

    addr_t addr_q;
    logic  bank_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_idle;
            rd_ack   <= 1'b0;
            bank_sel <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (rd_req) begin
                        bank_sel <= rd_bank;
                        state    <= s_addr;
                    end
                end
                s_addr: begin
                    state <= s_capture; // Banks register the word here
                end
                s_capture: begin
                    rd_ack <= 1'b1;
                    state  <= s_hold;
                end
                s_hold: begin
                    if (!rd_req) begin
                        rd_ack <= 1'b0;
                        state  <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && rd_req)
            addr_q <= rd_addr;
        if (state == s_capture)
            rd_data <= bank_sel ? bank1.rd_data : bank0.rd_data;
    end

    // Both banks read the same address side by side
    assign bank0.rd_addr = addr_q;
    assign bank1.rd_addr = addr_q;

endmodule

// File: hw/capture_top.sv
`timescale 1ns/10ps

module capture_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rx,
    input  logic                              cap_req,
    input  logic                              cap_bank,
    output logic                              cap_ack,
    input  logic                              rd_req,
    input  logic [sample_pkg::addr_width-1:0] rd_addr,
    input  logic                              rd_bank,
    output logic                              rd_ack,
    output logic [sample_pkg::sample_width-1:0] rd_data
);

    logic [7:0] rx_data;
    logic       rx_valid;

    bank_if bank_if0 ();
    bank_if bank_if1 ();

    uart_byte_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    sample_writer u_writer (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .cap_req  (cap_req),
        .cap_bank (cap_bank),
        .cap_ack  (cap_ack),
        .bank0    (bank_if0.writer),
        .bank1    (bank_if1.writer)
    );

    sample_bank u_bank0 (
        .clk  (clk),
        .port (bank_if0.bank)
    );

    sample_bank u_bank1 (
        .clk  (clk),
        .port (bank_if1.bank)
    );

    // Reader picks one of the two bank outputs
    bank_reader u_reader (
        .clk     (clk),
        .reset   (reset),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_bank (rd_bank),
        .rd_ack  (rd_ack),
        .rd_data (rd_data),
        .bank0   (bank_if0.reader),
        .bank1   (bank_if1.reader)
    );

endmodule

// File: tests/capture_tb.sv
`timescale 1ns/10ps

module capture_tb;
    import sample_pkg::*;

    localparam int clk_period  = 8;
    localparam int ack_timeout = 4 * clks_per_bit; // Cycles allowed for an ack to rise
    localparam int n_captures  = 32;               // 30 captures plus 4 stray bytes
    localparam int n_reads     = 82;
    localparam int watchdog_ns = n_captures * 25 * clks_per_bit * clk_period
                               + n_reads * 20 * clk_period + 20000;

    logic       clk;
    logic       reset;
    logic       rx;
    logic       cap_req;
    logic       cap_bank;
    logic       cap_ack;
    logic       rd_req;
    logic [3:0] rd_addr;
    logic       rd_bank;
    logic       rd_ack;
    logic [9:0] rd_data;

    logic [15:0] lfsr_state;
    sample_t     shadow [0:1][0:bank_depth-1];
    bit          valid [0:1][0:bank_depth-1];
    int          shadow_ptr;
    sample_t     exp_q [$]; // Expected read results in request order
    bit          use_q [$];
    int          errors;
    int          checks;
    int          tests;

    capture_top u_capture_top (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .cap_req  (cap_req),
        .cap_bank (cap_bank),
        .cap_ack  (cap_ack),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_bank  (rd_bank),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Low byte gives bits 7:0, the second byte's two low bits give 9:8
    function automatic sample_t bytes_to_sample(input logic [7:0] lo, input logic [7:0] hi);
        sample_t s;
        s.value = {hi[1:0], lo};
        return s;
    endfunction

    function automatic sample_t expected_sample(input logic bank, input addr_t addr);
        return shadow[bank][addr];
    endfunction

    task automatic check_sample(input string name, input sample_t actual,
                                input sample_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected 0x%h actual 0x%h", name, expected.value, actual.value);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int i;
        rx = 1'b0; // Start bit
        repeat (clks_per_bit) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        rx = 1'b1;
        repeat (clks_per_bit) @(negedge clk);
    endtask

    task automatic do_capture(input logic bank, input sample_t s, input int hold);
        logic [7:0]  hi_byte;
        logic [15:0] junk;
        int          n;
        junk    = random_bits(6);
        hi_byte = {junk[5:0], s.value[9:8]}; // Junk in the upper bits
        cap_bank = bank;
        cap_req  = 1'b1;
        send_byte(s.value[7:0]);
        check_flag("cap_ack", cap_ack, 1'b0);
        send_byte(hi_byte);
        n = 0;
        while (!cap_ack && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!cap_ack) begin
            errors++;
            $display("cap_ack did not rise within %0d cycles of the second byte", ack_timeout);
        end
        shadow[bank][shadow_ptr] = bytes_to_sample(s.value[7:0], hi_byte);
        valid[bank][shadow_ptr]  = 1'b1;
        shadow_ptr = (shadow_ptr + 1) % bank_depth;
        repeat (hold) begin
            @(negedge clk);
            check_flag("cap_ack", cap_ack, 1'b1);
        end
        cap_req = 1'b0;
        @(negedge clk);
        check_flag("cap_ack", cap_ack, 1'b0);
        @(negedge clk); // Writer passes through its release state
    endtask

    // In strict mode rd_ack must rise on exactly the third cycle
    task automatic do_read(input logic bank, input addr_t addr, input int hold, input bit strict);
        sample_t expected;
        bit      use_it;
        int      n;
        expected = expected_sample(bank, addr);
        use_it   = valid[bank][addr];
        exp_q.push_back(expected);
        use_q.push_back(use_it);
        rd_bank = bank;
        rd_addr = addr;
        rd_req  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (strict)
                check_flag("rd_ack", rd_ack, n >= 3);
        end while (!rd_ack && n < (strict ? 3 : ack_timeout));
        if (!rd_ack && !strict) begin
            errors++;
            $display("rd_ack did not rise within %0d cycles of rd_req", ack_timeout);
        end
        repeat (hold) begin
            @(negedge clk);
            check_flag("rd_ack", rd_ack, 1'b1);
            if (use_it)
                check_sample("rd_data", rd_data, expected); // Must hold while acked
        end
        rd_req = 1'b0;
        @(negedge clk);
        check_flag("rd_ack", rd_ack, 1'b0);
    endtask

    task automatic read_all();
        int a;
        for (a = 0; a < bank_depth; a++) begin
            do_read(1'b0, addr_t'(a), 0, 1'b0);
            do_read(1'b1, addr_t'(a), 0, 1'b0);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests++;
        if (errors == errors_at_start)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errors_at_start);
    endtask

    // Compares each read result as rd_ack rises
    always @(negedge clk) begin : compare_reads
        logic    ack_seen;
        sample_t exp_s;
        bit      use_s;
        if (!reset) begin
            if (rd_ack === 1'b1 && !ack_seen) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("rd_ack rose with no read outstanding");
                end else begin
                    exp_s = exp_q.pop_front();
                    use_s = use_q.pop_front();
                    if (use_s)
                        check_sample("rd_data", rd_data, exp_s);
                end
            end
            ack_seen = (rd_ack === 1'b1);
        end else begin
            ack_seen = 1'b0;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns", watchdog_ns);
        $display("test failed");
        $finish;
    end

    initial begin
        int          start;
        int          k;
        int          base;
        sample_t     s;
        logic [15:0] r;
        reset    = 1'b1;
        rx       = 1'b1;
        cap_req  = 1'b0;
        cap_bank = 1'b0;
        rd_req   = 1'b0;
        rd_addr  = '0;
        rd_bank  = 1'b0;
        lfsr_state = 16'd64;
        shadow_ptr = 0;
        errors = 0;
        checks = 0;
        tests  = 0;

        start = errors;
        repeat (8) @(negedge clk);
        check_flag("cap_ack", cap_ack, 1'b0);
        check_flag("rd_ack", rd_ack, 1'b0);
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag("cap_ack", cap_ack, 1'b0);
            check_flag("rd_ack", rd_ack, 1'b0);
        end
        finish_test("reset", start);

        start = errors;
        s.value = 10'h2a5;
        do_capture(1'b0, s, 0);
        do_read(1'b0, 4'd0, 0, 1'b0);
        finish_test("single capture", start);

        start = errors;
        base = shadow_ptr;
        for (k = 0; k < 8; k++) begin
            r = random_bits(10);
            s.value = r[9:0];
            do_capture(k[0], s, 0); // Banks alternate
        end
        for (k = 0; k < 8; k++) begin
            do_read(1'b0, addr_t'((base + k) % bank_depth), 0, 1'b0);
            do_read(1'b1, addr_t'((base + k) % bank_depth), 0, 1'b0);
        end
        finish_test("banks kept apart", start);

        start = errors;
        for (k = 0; k < 20; k++) begin
            r = random_bits(10);
            s.value = r[9:0];
            r = random_bits(1);
            do_capture(r[0], s, 0);
        end
        read_all();
        finish_test("pointer wrap", start);

        start = errors;
        repeat (4) begin
            r = random_bits(8);
            send_byte(r[7:0]);
        end
        repeat (2 * clks_per_bit) @(negedge clk);
        read_all();
        finish_test("stray bytes", start);

        // Also shows the pointer did not move on stray bytes
        start = errors;
        base = shadow_ptr;
        r = random_bits(10);
        s.value = r[9:0];
        do_capture(1'b1, s, 10);
        do_read(1'b1, addr_t'(base), 10, 1'b1);
        finish_test("four-phase", start);

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads were never acknowledged", exp_q.size());
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: capture_top.f
hw/sample_pkg.sv
hw/bank_if.sv
hw/uart_byte_rx.sv
hw/sample_writer.sv
hw/sample_bank.sv
hw/bank_reader.sv
hw/capture_top.sv
tests/capture_tb.sv

// File: Bender.yml
package:
  name: capture_top

sources:
  - hw/sample_pkg.sv
  - hw/bank_if.sv
  - hw/uart_byte_rx.sv
  - hw/sample_writer.sv
  - hw/sample_bank.sv
  - hw/bank_reader.sv
  - hw/capture_top.sv
  - target: test
    files:
      - tests/capture_tb.sv
